//--- verilog/fsab_mem_pkg.sv
package fsab_mem_pkg;

	// Bus and controller widths
	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_MASK_W = 8;
	localparam int FSAB_DID_W  = 4;
	localparam int FSAB_ADDR_W = 31;
	localparam int FSAB_LEN_W  = 4;

	localparam int FSAB_LEN_MAX         = 8;   // Beats per burst
	localparam int FSAB_INITIAL_CREDITS = 4;   // Request slots on the bus
	localparam int MEM_BYTES_PER_WORD   = 16;  // Two beats per controller word

	// Queue geometry
	localparam int REQ_AW      = $clog2(FSAB_INITIAL_CREDITS);
	localparam int WDATA_DEPTH = FSAB_INITIAL_CREDITS * FSAB_LEN_MAX / 2;
	localparam int WDATA_AW    = $clog2(WDATA_DEPTH);
	localparam int HDR_DEPTH   = 8;
	localparam int HDR_AW      = $clog2(HDR_DEPTH);
	localparam int RDAT_AW     = $clog2(FSAB_LEN_MAX);
	localparam int READS_MAX   = 2;            // Reads in flight toward the bus

	typedef logic [FSAB_DATA_W-1:0]   fsab_data_t;
	typedef logic [FSAB_MASK_W-1:0]   fsab_mask_t;  // Set bit leaves the byte alone
	typedef logic [FSAB_DID_W-1:0]    fsab_did_t;
	typedef logic [FSAB_ADDR_W-1:0]   fsab_addr_t;
	typedef logic [FSAB_LEN_W-1:0]    fsab_len_t;
	typedef logic [2*FSAB_DATA_W-1:0] mem_data_t;
	typedef logic [2*FSAB_MASK_W-1:0] mem_mask_t;

	typedef enum logic {FSAB_READ = 1'b0, FSAB_WRITE = 1'b1} fsab_mode_e;
	typedef enum logic [2:0] {MIG_WRITE = 3'b000, MIG_READ = 3'b001} mem_cmd_e;

	typedef struct packed {
		fsab_mode_e mode;
		fsab_did_t  did;
		fsab_did_t  subdid;
		fsab_addr_t addr;
		fsab_len_t  len;
	} fsab_req_t;

	typedef struct packed {
		mem_data_t data;
		mem_mask_t mask;
	} mem_wword_t;

	typedef struct packed {
		fsab_did_t did;
		fsab_did_t subdid;
		fsab_len_t len;
	} resp_hdr_t;

	// Controller words needed for a burst of len beats
	function automatic fsab_len_t mem_words(fsab_len_t len);
		return fsab_len_t'((len + 5'd1) >> 1);
	endfunction

endpackage

//--- verilog/fsab_req_queue.sv
`timescale 1ns/1ps

module fsab_req_queue import fsab_mem_pkg::*; (
	input  logic      clk0_tb,
	input  logic      rst0_tb,
	input  logic      fsabo_valid,
	input  fsab_req_t fsabo_req,
	input  logic      req_pop,
	input  logic      word_queued,
	output fsab_req_t req,
	output logic      req_ready,
	output logic      req_start,
	output logic      beat_last
);

	fsab_req_t       req_mem [FSAB_INITIAL_CREDITS];
	logic [REQ_AW-1:0] wptr;
	logic [REQ_AW-1:0] rptr;
	logic [REQ_AW:0] ready_cnt;  // Requests with all data queued
	fsab_len_t       beats_rem;  // Write beats still to come
	logic            hdr_beat;

	assign hdr_beat  = fsabo_valid && beats_rem == '0;
	assign req_start = hdr_beat && fsabo_req.mode == FSAB_WRITE;  // First beat of a write
	assign beat_last = (req_start && fsabo_req.len <= 1) ||
	                   (fsabo_valid && beats_rem == 1);
	assign req_ready = ready_cnt != '0;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			wptr      <= '0;
			rptr      <= '0;
			ready_cnt <= '0;
			beats_rem <= '0;
		end else begin
			if (req_start && fsabo_req.len > 1)
				beats_rem <= fsabo_req.len - 1'b1;
			else if (fsabo_valid && beats_rem != '0)
				beats_rem <= beats_rem - 1'b1;

			if (hdr_beat)
				wptr <= wptr + 1'b1;
			if (req_pop)
				rptr <= rptr + 1'b1;

			if (word_queued && !req_pop)
				ready_cnt <= ready_cnt + 1'b1;
			else if (!word_queued && req_pop)
				ready_cnt <= ready_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (hdr_beat)
			req_mem[wptr] <= fsabo_req;
		if (req_pop)
			req <= req_mem[rptr];  // Visible the cycle after the pop
	end

endmodule

//--- verilog/fsab_wdata_queue.sv
`timescale 1ns/1ps

module fsab_wdata_queue import fsab_mem_pkg::*; (
	input  logic       clk0_tb,
	input  logic       rst0_tb,
	input  logic       fsabo_valid,
	input  fsab_data_t fsabo_data,
	input  fsab_mask_t fsabo_mask,
	input  logic       req_start,
	input  logic       beat_last,
	input  logic       wdata_pop,
	output mem_wword_t wword,
	output logic       word_queued
);

	mem_wword_t          wd_mem [WDATA_DEPTH];
	logic [WDATA_AW-1:0] wptr;
	logic [WDATA_AW-1:0] rptr;
	fsab_data_t          prev_data;
	fsab_mask_t          prev_mask;
	logic                have_prev;   // Low beat of a pair is held
	logic                in_write;    // Inside the data beats of a write
	logic                write_beat;
	logic                wr_en;
	mem_wword_t          wr_word;

	assign write_beat = req_start || in_write;

	always_comb begin
		wr_en        = 1'b0;
		wr_word.data = {fsabo_data, prev_data};  // Earlier beat goes low
		wr_word.mask = {fsabo_mask, prev_mask};
		if (fsabo_valid && !write_beat) begin
			// A read still takes one word so both queues stay in step
			wr_en        = 1'b1;
			wr_word.mask = '1;
		end else if (fsabo_valid && have_prev) begin
			wr_en = 1'b1;
		end else if (fsabo_valid && beat_last) begin
			wr_en        = 1'b1;                       // Odd final beat
			wr_word.data = {fsabo_data, fsabo_data};
			wr_word.mask = {{FSAB_MASK_W{1'b1}}, fsabo_mask};
		end
	end

	assign word_queued = wr_en && (beat_last || !write_beat);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			wptr      <= '0;
			rptr      <= '0;
			have_prev <= 1'b0;
			in_write  <= 1'b0;
		end else begin
			if (fsabo_valid) begin
				in_write  <= write_beat && !beat_last;
				have_prev <= write_beat && !have_prev && !beat_last;
			end
			if (wr_en)
				wptr <= wptr + 1'b1;
			if (wdata_pop)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (fsabo_valid) begin
			prev_data <= fsabo_data;
			prev_mask <= fsabo_mask;
		end
		if (wr_en)
			wd_mem[wptr] <= wr_word;
		if (wdata_pop)
			wword <= wd_mem[rptr];
	end

endmodule

//--- verilog/mem_cmd_issue.sv
`timescale 1ns/1ps

module mem_cmd_issue import fsab_mem_pkg::*; (
	input  logic       clk0_tb,
	input  logic       rst0_tb,
	input  fsab_req_t  req,
	input  logic       req_ready,
	input  mem_wword_t wword,
	input  logic       phy_init_done,
	input  logic       app_af_afull,
	input  logic       app_wdf_afull,
	input  logic       read_credit_ok,
	output logic       req_pop,
	output logic       wdata_pop,
	output logic       app_af_wren,
	output mem_cmd_e   app_af_cmd,
	output fsab_addr_t app_af_addr,
	output logic       app_wdf_wren,
	output mem_wword_t app_wdf_word,
	output logic       hdr_push,
	output resp_hdr_t  hdr,
	output logic       fsabo_credit
);

	logic       cmd_1a;     // Request and first word on the inputs
	logic       wd_1a;      // Further write word on wword
	logic       is_write;
	logic       stall;
	logic       send;
	fsab_len_t  words;
	fsab_len_t  left;       // Words of the burst after the current one
	fsab_len_t  rem_r;
	fsab_addr_t addr_r;

	assign is_write = req.mode == FSAB_WRITE;
	assign words    = mem_words(req.len);

	assign stall = (cmd_1a || wd_1a) &&
	               (app_af_afull || (is_write ? app_wdf_afull : !read_credit_ok));
	assign send  = (cmd_1a || wd_1a) && !stall;

	always_comb begin
		if (!cmd_1a)
			left = rem_r;
		else if (is_write && words > 1)
			left = words - 1'b1;
		else
			left = '0;
	end

	// Only start from an empty stage
	assign req_pop   = req_ready && phy_init_done && !cmd_1a && !wd_1a;
	assign wdata_pop = req_pop || (send && left != '0);

	assign app_af_wren  = cmd_1a && !stall;
	assign app_af_cmd   = is_write ? MIG_WRITE : MIG_READ;
	assign app_af_addr  = cmd_1a ? req.addr : addr_r;
	assign app_wdf_wren = ((cmd_1a && is_write) || wd_1a) && !stall;
	assign app_wdf_word = wword;

	assign hdr_push = app_af_wren && !is_write;  // Reads go on to the response side
	assign hdr      = '{did: req.did, subdid: req.subdid, len: req.len};

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			cmd_1a       <= 1'b0;
			wd_1a        <= 1'b0;
			rem_r        <= '0;
			addr_r       <= '0;
			fsabo_credit <= 1'b0;
		end else begin
			fsabo_credit <= send && left == '0;  // Slot free once the burst is done

			if (req_pop)
				cmd_1a <= 1'b1;
			else if (!stall)
				cmd_1a <= 1'b0;

			if (!stall)
				wd_1a <= send && left != '0;

			if (send) begin
				rem_r  <= (left != '0) ? left - 1'b1 : '0;
				addr_r <= app_af_addr + fsab_addr_t'(MEM_BYTES_PER_WORD);
			end
		end
	end

endmodule

//--- verilog/fsab_resp_path.sv
`timescale 1ns/1ps

module fsab_resp_path import fsab_mem_pkg::*; (
	input  logic       clk0_tb,
	input  logic       rst0_tb,
	input  logic       hdr_push,
	input  resp_hdr_t  hdr,
	input  logic       rd_data_valid,
	input  mem_data_t  rd_data,
	output logic       read_credit_ok,
	output logic       fsabi_valid,
	output fsab_did_t  fsabi_did,
	output fsab_did_t  fsabi_subdid,
	output fsab_data_t fsabi_data
);

	resp_hdr_t        hdr_mem [HDR_DEPTH];
	logic [HDR_AW:0]  hdr_wptr;
	logic [HDR_AW:0]  hdr_rptr;
	mem_data_t        rd_mem [FSAB_LEN_MAX];
	logic [RDAT_AW:0] rd_wptr;
	logic [RDAT_AW:0] rd_rptr;
	logic [RDAT_AW:0] words_avail;
	resp_hdr_t        head;
	resp_hdr_t        cur;        // Response being sent
	fsab_len_t        need_words;
	fsab_len_t        beats_left;
	mem_data_t        word_r;
	logic             half;       // High beat of word_r is next
	logic             start;
	logic             word_pop;
	logic             last_beat;
	logic [1:0]       credits;

	assign head        = hdr_mem[hdr_rptr[HDR_AW-1:0]];
	assign need_words  = mem_words(head.len);
	assign words_avail = rd_wptr - rd_rptr;

	// Whole response must be buffered, nothing stalls the bus side
	assign start = beats_left == '0 && hdr_wptr != hdr_rptr &&
	               words_avail >= need_words;
	assign word_pop  = start || (half && beats_left > 1);
	assign last_beat = beats_left == 1;

	assign read_credit_ok = credits != '0;
	assign fsabi_did      = cur.did;
	assign fsabi_subdid   = cur.subdid;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			hdr_wptr    <= '0;
			hdr_rptr    <= '0;
			rd_wptr     <= '0;
			rd_rptr     <= '0;
			beats_left  <= '0;
			half        <= 1'b0;
			fsabi_valid <= 1'b0;
			credits     <= 2'(READS_MAX);
		end else begin
			if (hdr_push)
				hdr_wptr <= hdr_wptr + 1'b1;
			if (rd_data_valid)
				rd_wptr <= rd_wptr + 1'b1;
			if (start)
				hdr_rptr <= hdr_rptr + 1'b1;
			if (word_pop)
				rd_rptr <= rd_rptr + 1'b1;

			if (start) begin
				beats_left <= head.len;
				half       <= 1'b0;
			end else if (beats_left != '0) begin
				beats_left <= beats_left - 1'b1;
				half       <= !half;
			end
			fsabi_valid <= beats_left != '0;

			case ({hdr_push, last_beat})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (hdr_push)
			hdr_mem[hdr_wptr[HDR_AW-1:0]] <= hdr;
		if (rd_data_valid)
			rd_mem[rd_wptr[RDAT_AW-1:0]] <= rd_data;
		if (start)
			cur <= head;
		if (word_pop)
			word_r <= rd_mem[rd_rptr[RDAT_AW-1:0]];
		fsabi_data <= half ? word_r[FSAB_DATA_W +: FSAB_DATA_W] : word_r[0 +: FSAB_DATA_W];
	end

endmodule

//--- verilog/fsab_mem_bridge.sv
`timescale 1ns/1ps

module fsab_mem_bridge import fsab_mem_pkg::*; (
	input  logic       clk0_tb,
	input  logic       rst0_tb,
	input  logic       fsabo_valid,
	input  fsab_req_t  fsabo_req,
	input  fsab_data_t fsabo_data,
	input  fsab_mask_t fsabo_mask,
	output logic       fsabo_credit,
	input  logic       phy_init_done,
	input  logic       app_af_afull,
	input  logic       app_wdf_afull,
	output logic       app_af_wren,
	output mem_cmd_e   app_af_cmd,
	output fsab_addr_t app_af_addr,
	output logic       app_wdf_wren,
	output mem_wword_t app_wdf_word,
	input  logic       rd_data_valid,
	input  mem_data_t  rd_data,
	output logic       fsabi_valid,
	output fsab_did_t  fsabi_did,
	output fsab_did_t  fsabi_subdid,
	output fsab_data_t fsabi_data
);

	fsab_req_t  req;
	mem_wword_t wword;
	resp_hdr_t  hdr;
	logic       req_ready, req_pop, req_start, beat_last;
	logic       wdata_pop, word_queued, hdr_push, read_credit_ok;

	fsab_req_queue u_fsab_req_queue (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .fsabo_valid(fsabo_valid),
		.fsabo_req(fsabo_req), .req_pop(req_pop), .word_queued(word_queued),
		.req(req), .req_ready(req_ready), .req_start(req_start), .beat_last(beat_last)
	);

	fsab_wdata_queue u_fsab_wdata_queue (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .fsabo_valid(fsabo_valid),
		.fsabo_data(fsabo_data), .fsabo_mask(fsabo_mask), .req_start(req_start),
		.beat_last(beat_last), .wdata_pop(wdata_pop), .wword(wword),
		.word_queued(word_queued)
	);

	mem_cmd_issue u_mem_cmd_issue (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .req(req), .req_ready(req_ready),
		.wword(wword), .phy_init_done(phy_init_done), .app_af_afull(app_af_afull),
		.app_wdf_afull(app_wdf_afull), .read_credit_ok(read_credit_ok),
		.req_pop(req_pop), .wdata_pop(wdata_pop), .app_af_wren(app_af_wren),
		.app_af_cmd(app_af_cmd), .app_af_addr(app_af_addr), .app_wdf_wren(app_wdf_wren),
		.app_wdf_word(app_wdf_word), .hdr_push(hdr_push), .hdr(hdr),
		.fsabo_credit(fsabo_credit)
	);

	fsab_resp_path u_fsab_resp_path (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .hdr_push(hdr_push), .hdr(hdr),
		.rd_data_valid(rd_data_valid), .rd_data(rd_data), .read_credit_ok(read_credit_ok),
		.fsabi_valid(fsabi_valid), .fsabi_did(fsabi_did), .fsabi_subdid(fsabi_subdid),
		.fsabi_data(fsabi_data)
	);

endmodule

//--- test/fsab_mem_check.svh
`ifndef FSAB_MEM_CHECK_SVH
`define FSAB_MEM_CHECK_SVH

task automatic report_error(input string msg);
	error_cnt++;
	$display("[FAIL] t=%0t ns: %s", $time, msg);
	$display("Simulation finished: FAIL");
	$fatal(1, "Run stopped at the first error");
endtask

task automatic check_cmd(input mem_cmd_e exp_cmd, input fsab_addr_t exp_addr,
		input mem_cmd_e got_cmd, input fsab_addr_t got_addr);
	if (exp_cmd != got_cmd || exp_addr != got_addr)
		report_error($sformatf("command %s @%h, expected %s @%h",
			got_cmd.name(), got_addr, exp_cmd.name(), exp_addr));
endtask

task automatic check_word(input mem_wword_t exp_w, input mem_wword_t got_w);
	logic ok;
	ok = exp_w.mask == got_w.mask;
	for (int i = 0; i < 2*FSAB_MASK_W; i++)  // Masked bytes carry no data
		if (!exp_w.mask[i] && exp_w.data[8*i +: 8] != got_w.data[8*i +: 8])
			ok = 1'b0;
	if (!ok)
		report_error($sformatf("write word %h/%h, expected %h/%h",
			got_w.data, got_w.mask, exp_w.data, exp_w.mask));
endtask

task automatic check_beat(input fsab_did_t exp_did, input fsab_did_t exp_sub,
		input fsab_data_t exp_data, input fsab_did_t got_did, input fsab_did_t got_sub,
		input fsab_data_t got_data);
	if (exp_did != got_did || exp_sub != got_sub || exp_data != got_data)
		report_error($sformatf("response %h.%h %h, expected %h.%h %h",
			got_did, got_sub, got_data, exp_did, exp_sub, exp_data));
endtask

`endif

//--- test/fsab_mem_bridge_tb.sv
`timescale 1ns/1ps

module fsab_mem_bridge_tb import fsab_mem_pkg::*; ();

	localparam int NUM_LINES  = 8;
	localparam int LINE_WORDS = 21;  // mode did subdid addr len, 8 beats, 8 masks
	localparam int CLK_PERIOD = 8;
	localparam int RD_DELAY   = 4;   // Controller read latency in cycles
	localparam int TIMEOUT_CYCLES = 10 + 20 + 200 * NUM_LINES;

	logic       clk0_tb, rst0_tb, fsabo_valid, fsabo_credit;
	fsab_req_t  fsabo_req;
	fsab_data_t fsabo_data, fsabi_data;
	fsab_mask_t fsabo_mask;
	logic       phy_init_done, app_af_afull, app_wdf_afull, app_af_wren, app_wdf_wren;
	mem_cmd_e   app_af_cmd;
	fsab_addr_t app_af_addr;
	mem_wword_t app_wdf_word;
	logic       rd_data_valid, fsabi_valid;
	mem_data_t  rd_data;
	fsab_did_t  fsabi_did, fsabi_subdid;

	logic [63:0] td [NUM_LINES*LINE_WORDS];
	logic [7:0]  mem_bytes [fsab_addr_t];   // Controller memory model
	mem_cmd_e    exp_cmd_q[$];
	fsab_addr_t  exp_addr_q[$], word_addr_q[$];
	fsab_len_t   cmd_len_q[$], exp_len_q[$];
	mem_wword_t  exp_word_q[$];
	fsab_did_t   exp_did_q[$], exp_sub_q[$];
	fsab_data_t  exp_beat_q[$];
	mem_data_t   rd_q[$];
	int          rd_due_q[$];
	int          cycle = 0, sent = 0, returned = 0, error_cnt = 0, resp_left = 0;
	int          af_span = 0, wdf_span = 0;
	integer      seed = 32'habd6;

	`include "fsab_mem_check.svh"

	fsab_mem_bridge u_fsab_mem_bridge (.*);

	function automatic logic [63:0] field(int line, int idx);
		return td[line*LINE_WORDS + idx];
	endfunction

	function automatic logic [7:0] mem_byte(fsab_addr_t a);
		if (mem_bytes.exists(a))
			return mem_bytes[a];
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {1'b0, a[30:24]};  // Unwritten fill
	endfunction

	function automatic mem_data_t read_word(fsab_addr_t a);
		mem_data_t w;
		for (int i = 0; i < 16; i++)
			w[8*i +: 8] = mem_byte(fsab_addr_t'(a + i));
		return w;
	endfunction

	task automatic build_expected();
		fsab_len_t  len;
		fsab_addr_t addr;
		mem_wword_t w;
		logic       is_wr;
		for (int l = 0; l < NUM_LINES; l++) begin
			len   = fsab_len_t'(field(l, 4));
			addr  = fsab_addr_t'(field(l, 3));
			is_wr = field(l, 0) != '0;
			exp_cmd_q.push_back(is_wr ? MIG_WRITE : MIG_READ);
			exp_addr_q.push_back(addr);
			cmd_len_q.push_back(len);
			if (is_wr) begin
				for (int k = 0; 2*k < len; k++) begin
					w.data[63:0] = field(l, 5 + 2*k);
					w.mask[7:0]  = fsab_mask_t'(field(l, 13 + 2*k));
					w.data[127:64] = (2*k + 1 < len) ? field(l, 6 + 2*k) : '0;
					w.mask[15:8]   = (2*k + 1 < len) ?
					                 fsab_mask_t'(field(l, 14 + 2*k)) : '1;  // Odd pad
					exp_word_q.push_back(w);
					word_addr_q.push_back(fsab_addr_t'(addr + 16*k));
				end
			end else begin
				exp_len_q.push_back(len);
				for (int b = 0; b < len; b++) begin
					exp_did_q.push_back(fsab_did_t'(field(l, 1)));
					exp_sub_q.push_back(fsab_did_t'(field(l, 2)));
					exp_beat_q.push_back(field(l, 5 + b));
				end
			end
		end
	endtask

	task automatic send_request(int l);
		fsab_req_t r;
		int        nbeats;
		while (FSAB_INITIAL_CREDITS - sent + returned <= 0) begin  // Out of credit
			fsabo_valid <= 1'b0;
			@(posedge clk0_tb);
		end
		r.mode   = (field(l, 0) != '0) ? FSAB_WRITE : FSAB_READ;
		r.did    = fsab_did_t'(field(l, 1));
		r.subdid = fsab_did_t'(field(l, 2));
		r.addr   = fsab_addr_t'(field(l, 3));
		r.len    = fsab_len_t'(field(l, 4));
		nbeats   = (r.mode == FSAB_WRITE) ? r.len : 1;
		for (int b = 0; b < nbeats; b++) begin
			fsabo_valid <= 1'b1;
			fsabo_req   <= r;
			fsabo_data  <= field(l, 5 + b);
			fsabo_mask  <= fsab_mask_t'(field(l, 13 + b));
			if (b == 0)
				sent <= sent + 1;
			@(posedge clk0_tb);
		end
	endtask

	initial begin
		clk0_tb = 1'b0;
		forever #(CLK_PERIOD/2) clk0_tb = ~clk0_tb;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the bridge did not finish all requests in time");
		$display("Simulation finished: FAIL");
		$fatal(1, "Watchdog expired");
	end

	// Short random almost-full spans from the controller
	always @(posedge clk0_tb) begin
		if (af_span != 0)
			af_span--;
		else if (($random(seed) & 15) == 0)
			af_span = 1 + ($random(seed) & 3);
		if (wdf_span != 0)
			wdf_span--;
		else if (($random(seed) & 15) == 0)
			wdf_span = 1 + ($random(seed) & 3);
		app_af_afull  <= af_span != 0;
		app_wdf_afull <= wdf_span != 0;
	end

	// Controller model and bus monitors
	always @(posedge clk0_tb) begin
		if (!rst0_tb) begin
			cycle++;
			if (app_af_wren) begin
				if (!phy_init_done)
					report_error("command issued before phy_init_done");
				if (app_af_afull)
					report_error("command strobe while app_af_afull is high");
				if (exp_cmd_q.size() == 0)
					report_error("command strobe with no request pending");
				check_cmd(exp_cmd_q[0], exp_addr_q[0], app_af_cmd, app_af_addr);
				if (app_af_cmd == MIG_READ)
					for (int k = 0; 2*k < cmd_len_q[0]; k++) begin
						rd_q.push_back(read_word(fsab_addr_t'(app_af_addr + 16*k)));
						rd_due_q.push_back(cycle + RD_DELAY);
					end
				void'(exp_cmd_q.pop_front());
				void'(exp_addr_q.pop_front());
				void'(cmd_len_q.pop_front());
			end
			if (app_wdf_wren) begin
				if (app_wdf_afull || app_af_afull)
					report_error("write data strobe while the controller is almost full");
				if (exp_word_q.size() == 0)
					report_error("write data strobe with no word expected");
				check_cmd(MIG_WRITE, word_addr_q[0], app_af_cmd, app_af_addr);  // Word address
				check_word(exp_word_q.pop_front(), app_wdf_word);
				for (int i = 0; i < 16; i++)  // Masked bytes stay as they were
					if (!app_wdf_word.mask[i])
						mem_bytes[fsab_addr_t'(word_addr_q[0] + i)] = app_wdf_word.data[8*i +: 8];
				void'(word_addr_q.pop_front());
			end
			rd_data_valid <= 1'b0;
			if (rd_q.size() != 0 && rd_due_q[0] <= cycle) begin
				rd_data_valid <= 1'b1;
				rd_data       <= rd_q.pop_front();
				void'(rd_due_q.pop_front());
			end
			if (fsabo_credit) begin
				if (returned >= sent)
					report_error("credit returned with no request outstanding");
				returned <= returned + 1;
			end
			if (fsabi_valid) begin
				if (exp_beat_q.size() == 0)
					report_error("response beat with no read pending");
				if (resp_left == 0)
					resp_left = exp_len_q.pop_front();
				check_beat(exp_did_q.pop_front(), exp_sub_q.pop_front(), exp_beat_q.pop_front(),
					fsabi_did, fsabi_subdid, fsabi_data);
				resp_left--;
			end else if (resp_left != 0) begin
				report_error("response ended before len beats");
			end
		end
	end

	initial begin
		rst0_tb       = 1'b1;
		fsabo_valid   = 1'b0;
		fsabo_req     = '0;
		fsabo_data    = '0;
		fsabo_mask    = '0;
		phy_init_done = 1'b0;
		app_af_afull  = 1'b0;
		app_wdf_afull = 1'b0;
		rd_data_valid = 1'b0;
		rd_data       = '0;
		$readmemh("test/fsab_mem_testdata.txt", td);
		build_expected();
		repeat (10) @(posedge clk0_tb);
		rst0_tb <= 1'b0;
		fork
			begin
				repeat (20) @(posedge clk0_tb);  // Controller still calibrating
				phy_init_done <= 1'b1;
			end
		join_none
		for (int l = 0; l < NUM_LINES; l++)
			send_request(l);
		fsabo_valid <= 1'b0;
		while (exp_cmd_q.size() != 0 || exp_word_q.size() != 0 || exp_beat_q.size() != 0)
			@(posedge clk0_tb);
		repeat (5) @(posedge clk0_tb);
		if (FSAB_INITIAL_CREDITS - sent + returned != FSAB_INITIAL_CREDITS)
			report_error("credit count did not return to its initial value");
		if (error_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- test/fsab_mem_testdata.txt
// mode did subdid addr len, then data0..data7 and mask0..mask7 (hex, mask bit 1 = keep byte)
// For a read the data columns hold the expected response beats
1 1 2 100 2 1234567811111111 2222 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 110 3 3333 4444 5555 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 3 100 1 99999999aaaaaaaa 0 0 0 0 0 0 0 f0 0 0 0 0 0 0 0
0 5 6 100 2 12345678aaaaaaaa 2222 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 7 1 110 3 3333 4444 5555 0 0 0 0 0 0 0 0 0 0 0 0 0
1 2 0 200 8 dead 102 103 104 105 106 107 108 ff 0 0 0 0 0 0 0
0 3 4 200 8 0504070601000302 102 103 104 105 106 107 108 0 0 0 0 0 0 0 0
0 9 a 300 1 0405060700010203 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- fsab_mem_bridge.f
+incdir+test
verilog/fsab_mem_pkg.sv
verilog/fsab_req_queue.sv
verilog/fsab_wdata_queue.sv
verilog/mem_cmd_issue.sv
verilog/fsab_resp_path.sv
verilog/fsab_mem_bridge.sv
test/fsab_mem_bridge_tb.sv

//--- Bender.yml
package:
  name: fsab_mem_bridge

sources:
  - verilog/fsab_mem_pkg.sv
  - verilog/fsab_req_queue.sv
  - verilog/fsab_wdata_queue.sv
  - verilog/mem_cmd_issue.sv
  - verilog/fsab_resp_path.sv
  - verilog/fsab_mem_bridge.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/fsab_mem_bridge_tb.sv
